/* tuner_cfg_pkg.sv */
// -----------------------------
// Tuner config package
// Datapath widths, peak window
// sizes and the vector types of
// the ring tuner search engine
// -----------------------------

package tuner_cfg_pkg;

  // Converter widths
  localparam int DacWidth = 8;
  localparam int AdcWidth = 8;

  // Peak table depth
  localparam int NumTarget = 8;

  // ------------------------------
  // Peak window geometry
  // ------------------------------
  localparam int PeakWinHalf  = 4;
  localparam int PeakWinSize  = 2 * PeakWinHalf + 1;
  // Candidate sits just below the middle
  localparam int PeakTrackIdx = PeakWinHalf - 1;
  // Minimum agreeing flags per half
  localparam int PeakThres    = 2;
  // Samples blocked after a peak
  localparam int PeakInvalidMax = 4 * PeakThres;

  // Datapath vectors
  typedef logic [DacWidth-1:0] tune_code_t;
  typedef logic [AdcWidth-1:0] pwr_t;
  typedef logic [2:0]          stride_t;
  typedef logic [8:0]          sample_cnt_t;
  typedef logic [3:0]          peak_cnt_t;

endpackage

/* tuner_search_pkg.sv */
// -----------------------------
// Tuner search package
// State encodings and the packed
// records passed between the
// search engine blocks
// -----------------------------

package tuner_search_pkg;

  // Top-level search FSM
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    INIT   = 2'd1,
    ACTIVE = 2'd2,
    DONE   = 2'd3
  } search_state_e;

  // Arbiter exchange sub-state inside ACTIVE
  typedef enum logic {
    CTRL_TUNE   = 1'b0,
    CTRL_UPDATE = 1'b1
  } ctrl_state_e;

  // Sweep range and step exponent, 19 bits
  typedef struct packed {
    tuner_cfg_pkg::tune_code_t start_code;
    tuner_cfg_pkg::tune_code_t end_code;
    tuner_cfg_pkg::stride_t    stride;
  } sweep_cfg_t;

  // One committed point of the sweep, 16 bits
  typedef struct packed {
    tuner_cfg_pkg::tune_code_t code;
    tuner_cfg_pkg::pwr_t       pwr;
  } sample_t;

  // Peak table, entry 0 in the low bits
  typedef sample_t [tuner_cfg_pkg::NumTarget-1:0] peak_tbl_t;

endpackage

/* search_ctrl.sv */
// -----------------------------
// Search controller
// Main search FSM, the tune and
// commit exchange with the ring
// arbiter, and sample counting
// -----------------------------
`timescale 1ns/10ps

module search_ctrl (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  tuner_search_pkg::sweep_cfg_t i_cfg,
  input  logic                         i_trig_val,
  input  logic                         i_peaks_rdy,
  input  logic                         i_tune_rdy,
  input  logic                         i_commit_val,
  input  logic                         i_compute_done,
  output logic                         o_trig_rdy,
  output logic                         o_peaks_val,
  output logic                         o_ctrl_active,
  output logic                         o_tune_val,
  output logic                         o_commit_rdy,
  output logic                         o_refresh,
  output logic                         o_tune_state,
  output logic                         o_update,
  output tuner_cfg_pkg::sample_cnt_t   o_sample_cnt
);

  tuner_search_pkg::search_state_e state, state_next;
  tuner_search_pkg::ctrl_state_e   sub_state, sub_state_next;

  logic                       trig_fire;
  logic                       tune_fire;
  logic                       commit_fire;
  logic                       is_active;
  logic                       sweep_done;
  tuner_cfg_pkg::tune_code_t  span;
  tuner_cfg_pkg::sample_cnt_t cnt_max;
  tuner_cfg_pkg::sample_cnt_t sample_cnt;

  // ------------------------------
  // Handshake decode
  // ------------------------------
  assign o_trig_rdy  = (state == tuner_search_pkg::IDLE) || (state == tuner_search_pkg::DONE);
  assign o_peaks_val = (state == tuner_search_pkg::DONE);
  assign trig_fire   = o_trig_rdy && i_trig_val;

  assign is_active     = (state == tuner_search_pkg::ACTIVE);
  assign o_ctrl_active = is_active;
  assign o_refresh     = (state == tuner_search_pkg::INIT);
  assign o_tune_state  = is_active && (sub_state == tuner_search_pkg::CTRL_TUNE);
  // Offer the code only once the sweep has stepped it
  assign o_tune_val    = o_tune_state && i_compute_done;
  assign o_commit_rdy  = is_active && (sub_state == tuner_search_pkg::CTRL_UPDATE);

  assign tune_fire   = o_tune_val && i_tune_rdy;
  assign commit_fire = o_commit_rdy && i_commit_val;
  // Sample strobe
  assign o_update    = commit_fire;

  // ------------------------------
  // Search FSM
  // ------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= tuner_search_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      tuner_search_pkg::IDLE:   if (trig_fire) state_next = tuner_search_pkg::INIT;
      // Single clearing cycle
      tuner_search_pkg::INIT:   state_next = tuner_search_pkg::ACTIVE;
      tuner_search_pkg::ACTIVE: if (sweep_done) state_next = tuner_search_pkg::DONE;
      // Results held here until retriggered
      tuner_search_pkg::DONE:   if (trig_fire) state_next = tuner_search_pkg::INIT;
      default:                  state_next = tuner_search_pkg::IDLE;
    endcase
  end

  // ------------------------------
  // Arbiter sub-FSM
  // ------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      sub_state <= tuner_search_pkg::CTRL_TUNE;
    end else if (o_refresh) begin
      sub_state <= tuner_search_pkg::CTRL_TUNE;
    end else begin
      sub_state <= sub_state_next;
    end
  end

  always_comb begin
    sub_state_next = sub_state;
    if (is_active) begin
      case (sub_state)
        tuner_search_pkg::CTRL_TUNE:   if (tune_fire) sub_state_next = tuner_search_pkg::CTRL_UPDATE;
        tuner_search_pkg::CTRL_UPDATE: if (commit_fire) sub_state_next = tuner_search_pkg::CTRL_TUNE;
        default:                       sub_state_next = tuner_search_pkg::CTRL_TUNE;
      endcase
    end
  end

  // ------------------------------
  // Sample count and sweep end
  // ------------------------------
  assign span       = i_cfg.end_code - i_cfg.start_code;
  assign cnt_max    = {1'b0, span >> i_cfg.stride};
  assign sweep_done = (sample_cnt >= cnt_max);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      sample_cnt <= '0;
    end else if (o_refresh) begin
      sample_cnt <= '0;
    end else if (o_update) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  assign o_sample_cnt = sample_cnt;

  // Arbiter sees at most one open request
  a_tune_commit_excl : assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_tune_val && o_commit_rdy));

  // Samples arrive only while the ring is owned
  a_update_active : assert property (@(posedge i_clk) disable iff (i_rst)
    o_update |-> is_active);

endmodule

/* ring_sweep.sv */
// -----------------------------
// Ring sweep
// Steps the DAC tuning code by
// two to the stride per sample
// -----------------------------
`timescale 1ns/10ps

module ring_sweep (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  tuner_search_pkg::sweep_cfg_t i_cfg,
  input  logic                         i_refresh,
  input  logic                         i_tune_state,
  input  logic                         i_update,
  output tuner_cfg_pkg::tune_code_t    o_ring_tune,
  output logic                         o_compute_done
);

  tuner_cfg_pkg::tune_code_t step;
  tuner_cfg_pkg::tune_code_t ring_tune;
  logic                      compute_done;
  logic                      compute;

  assign step    = tuner_cfg_pkg::tune_code_t'(1) << i_cfg.stride;
  // First tune-state cycle of each sample
  assign compute = i_tune_state && !compute_done;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      ring_tune <= '0;
    end else if (i_refresh) begin
      ring_tune <= i_cfg.start_code;
    end else if (compute) begin
      ring_tune <= ring_tune + step;
    end
  end

  // Single-cycle compute, rearmed by the sample strobe
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      compute_done <= 1'b0;
    end else if (i_refresh || i_update) begin
      compute_done <= 1'b0;
    end else if (i_tune_state) begin
      compute_done <= 1'b1;
    end
  end

  assign o_ring_tune    = ring_tune;
  assign o_compute_done = compute_done;

endmodule

/* peak_window.sv */
// -----------------------------
// Peak window
// Sliding history of committed
// samples with slope flags and
// majority votes on each half
// -----------------------------
`timescale 1ns/10ps

module peak_window (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_refresh,
  input  logic                      i_update,
  input  tuner_search_pkg::sample_t i_commit,
  output tuner_search_pkg::sample_t o_cand,
  output logic                      o_peak_found
);

  localparam int Size = tuner_cfg_pkg::PeakWinSize;
  localparam int Half = tuner_cfg_pkg::PeakWinHalf;

  tuner_search_pkg::sample_t last;
  // Entry 0 is the newest
  tuner_search_pkg::sample_t hist [Size];
  logic [Size-1:0]           rise_hist;
  logic [Size-1:0]           fall_hist;
  logic                      rise_now;
  logic                      fall_now;
  logic                      rise_vote;
  logic                      fall_vote;

  // Count set flags in one half
  function automatic logic majority(input logic [Half-1:0] flags);
    int sum;
    sum = 0;
    for (int i = 0; i < Half; i++) begin
      sum += int'(flags[i]);
    end
    return (sum >= tuner_cfg_pkg::PeakThres);
  endfunction

  // ------------------------------
  // Sample history
  // ------------------------------
  // Last commit enters the window on the next strobe
  always_ff @(posedge i_clk) begin
    if (i_refresh) begin
      last <= '0;
      for (int j = 0; j < Size; j++) begin
        hist[j] <= '0;
      end
    end else if (i_update) begin
      last    <= i_commit;
      hist[0] <= last;
      for (int j = 1; j < Size; j++) begin
        hist[j] <= hist[j-1];
      end
    end
  end

  // ------------------------------
  // Slope flags
  // ------------------------------
  assign rise_now = hist[0].pwr > hist[1].pwr;
  assign fall_now = hist[0].pwr < hist[1].pwr;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      rise_hist <= '0;
      fall_hist <= '0;
    end else if (i_refresh) begin
      rise_hist <= '0;
      fall_hist <= '0;
    end else if (i_update) begin
      rise_hist <= {rise_hist[Size-2:0], rise_now};
      fall_hist <= {fall_hist[Size-2:0], fall_now};
    end
  end

  // Older half rising, newer half falling
  assign rise_vote    = majority(rise_hist[Size-1:Half+1]);
  assign fall_vote    = majority(fall_hist[Half-1:0]);
  assign o_peak_found = rise_vote && fall_vote;
  assign o_cand       = hist[tuner_cfg_pkg::PeakTrackIdx];

endmodule

/* peak_store.sv */
// -----------------------------
// Peak store
// Block-out of nearby peaks and
// the table of accepted peaks
// -----------------------------
`timescale 1ns/10ps

module peak_store (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_refresh,
  input  logic                        i_update,
  input  logic                        i_peak_found,
  input  tuner_search_pkg::sample_t   i_cand,
  input  tuner_cfg_pkg::sample_cnt_t  i_sample_cnt,
  output tuner_search_pkg::peak_tbl_t o_peaks,
  output tuner_cfg_pkg::peak_cnt_t    o_peaks_cnt
);

  localparam int InvW = $clog2(tuner_cfg_pkg::PeakInvalidMax);
  localparam int IdxW = $clog2(tuner_cfg_pkg::NumTarget);

  logic [InvW-1:0]             invalid_cnt;
  logic                        invalid;
  logic                        table_full;
  logic                        commit;
  tuner_cfg_pkg::peak_cnt_t    peak_cnt;
  tuner_search_pkg::peak_tbl_t peak_tbl;

  // ------------------------------
  // Peak invalidation
  // ------------------------------
  // Blocked during the first window fill and after any peak
  assign invalid = (invalid_cnt != '0) || (i_sample_cnt <= tuner_cfg_pkg::PeakWinSize);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      invalid_cnt <= '0;
    end else if (i_refresh) begin
      invalid_cnt <= '0;
    end else if (i_update) begin
      // Counter wraps to zero after the block-out length
      if (i_peak_found || invalid) begin
        invalid_cnt <= invalid_cnt + 1'b1;
      end else begin
        invalid_cnt <= '0;
      end
    end
  end

  // ------------------------------
  // Peak table
  // ------------------------------
  assign table_full = (peak_cnt >= tuner_cfg_pkg::NumTarget);
  assign commit     = i_update && i_peak_found && !invalid && !table_full;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      peak_cnt <= '0;
    end else if (i_refresh) begin
      peak_cnt <= '0;
    end else if (commit) begin
      peak_cnt <= peak_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_refresh) begin
      peak_tbl <= '0;
    end else if (commit) begin
      peak_tbl[peak_cnt[IdxW-1:0]] <= i_cand;
    end
  end

  assign o_peaks     = peak_tbl;
  assign o_peaks_cnt = peak_cnt;

  // Storing stops at a full table
  a_cnt_bound : assert property (@(posedge i_clk) disable iff (i_rst)
    o_peaks_cnt <= tuner_cfg_pkg::NumTarget);

endmodule

/* tuner_search_top.sv */
// -----------------------------
// Tuner search top
// Ring resonator peak search
// engine with arbiter handshake
// -----------------------------
`timescale 1ns/10ps

module tuner_search_top (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  tuner_search_pkg::sweep_cfg_t i_cfg,
  // Trigger
  input  logic                         i_trig_val,
  output logic                         o_trig_rdy,
  // Tune request
  output logic                         o_tune_val,
  output tuner_cfg_pkg::tune_code_t    o_ring_tune,
  input  logic                         i_tune_rdy,
  // Commit
  output logic                         o_commit_rdy,
  input  logic                         i_commit_val,
  input  tuner_search_pkg::sample_t    i_commit,
  output logic                         o_ctrl_active,
  // Results
  output logic                         o_peaks_val,
  output tuner_search_pkg::peak_tbl_t  o_peaks,
  output tuner_cfg_pkg::peak_cnt_t     o_peaks_cnt,
  input  logic                         i_peaks_rdy
);

  logic                       refresh;
  logic                       tune_state;
  logic                       update;
  logic                       compute_done;
  logic                       peak_found;
  tuner_cfg_pkg::sample_cnt_t sample_cnt;
  tuner_search_pkg::sample_t  cand;

  search_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_cfg          (i_cfg),
    .i_trig_val     (i_trig_val),
    .i_peaks_rdy    (i_peaks_rdy),
    .i_tune_rdy     (i_tune_rdy),
    .i_commit_val   (i_commit_val),
    .i_compute_done (compute_done),
    .o_trig_rdy     (o_trig_rdy),
    .o_peaks_val    (o_peaks_val),
    .o_ctrl_active  (o_ctrl_active),
    .o_tune_val     (o_tune_val),
    .o_commit_rdy   (o_commit_rdy),
    .o_refresh      (refresh),
    .o_tune_state   (tune_state),
    .o_update       (update),
    .o_sample_cnt   (sample_cnt)
  );

  ring_sweep u_sweep (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_cfg          (i_cfg),
    .i_refresh      (refresh),
    .i_tune_state   (tune_state),
    .i_update       (update),
    .o_ring_tune    (o_ring_tune),
    .o_compute_done (compute_done)
  );

  peak_window u_window (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_refresh    (refresh),
    .i_update     (update),
    .i_commit     (i_commit),
    .o_cand       (cand),
    .o_peak_found (peak_found)
  );

  peak_store u_store (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_refresh    (refresh),
    .i_update     (update),
    .i_peak_found (peak_found),
    .i_cand       (cand),
    .i_sample_cnt (sample_cnt),
    .o_peaks      (o_peaks),
    .o_peaks_cnt  (o_peaks_cnt)
  );

endmodule

/* tb_search_checker.sv */
// -----------------------------
// Search checker
// Reference window and peak
// model, compares DUT results
// -----------------------------
`timescale 1ns/10ps

module tb_search_checker (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  tuner_search_pkg::sweep_cfg_t i_cfg,
  input  tuner_cfg_pkg::sample_cnt_t   i_exp_samples,
  input  logic                         i_trig_val,
  input  logic                         i_trig_rdy,
  input  logic                         i_tune_val,
  input  logic                         i_tune_rdy,
  input  tuner_cfg_pkg::tune_code_t    i_ring_tune,
  input  logic                         i_commit_rdy,
  input  logic                         i_commit_val,
  input  tuner_search_pkg::sample_t    i_commit,
  input  logic                         i_ctrl_active,
  input  logic                         i_peaks_val,
  input  logic                         i_peaks_rdy,
  input  tuner_search_pkg::peak_tbl_t  i_peaks,
  input  tuner_cfg_pkg::peak_cnt_t     i_peaks_cnt,
  output int                           o_tests,
  output int                           o_checks,
  output int                           o_errors
);

  localparam int Size = tuner_cfg_pkg::PeakWinSize;
  localparam int Half = tuner_cfg_pkg::PeakWinHalf;

  tuner_search_pkg::sample_t   win_last;
  // Index 0 holds the newest sample
  tuner_search_pkg::sample_t   win_hist [Size];
  tuner_search_pkg::sample_t   exp_tbl [tuner_cfg_pkg::NumTarget];
  logic [Size-1:0]             rise_flags;
  logic [Size-1:0]             fall_flags;
  int                          block_cnt;
  int                          n_samples;
  int                          exp_cnt;
  int                          n_tunes;
  int                          test_errs;
  logic                        hold_prev;
  tuner_search_pkg::peak_tbl_t prev_peaks;
  tuner_cfg_pkg::peak_cnt_t    prev_cnt;

  initial begin
    o_tests   = 0;
    o_checks  = 0;
    o_errors  = 0;
    test_errs = 0;
    hold_prev = 1'b0;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      test_errs++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic int count_set(input logic [Half-1:0] flags);
    int n;
    n = 0;
    for (int i = 0; i < Half; i++) begin
      n += int'(flags[i]);
    end
    return n;
  endfunction

  // ------------------------------
  // Reference peak model
  // ------------------------------
  task automatic clear_model();
    win_last   = '0;
    rise_flags = '0;
    fall_flags = '0;
    block_cnt  = 0;
    n_samples  = 0;
    exp_cnt    = 0;
    n_tunes    = 0;
    test_errs  = 0;
    for (int j = 0; j < Size; j++) begin
      win_hist[j] = '0;
    end
    for (int j = 0; j < tuner_cfg_pkg::NumTarget; j++) begin
      exp_tbl[j] = '0;
    end
  endtask

  // Votes and block-out judged on the window before this sample enters
  task automatic apply_sample(input tuner_search_pkg::sample_t s);
    logic found;
    logic blocked;
    logic rise_now;
    logic fall_now;
    found = (count_set(rise_flags[Size-1:Half+1]) >= tuner_cfg_pkg::PeakThres) &&
            (count_set(fall_flags[Half-1:0]) >= tuner_cfg_pkg::PeakThres);
    blocked = (block_cnt != 0) || (n_samples <= Size);
    if (found && !blocked && exp_cnt < tuner_cfg_pkg::NumTarget) begin
      exp_tbl[exp_cnt] = win_hist[tuner_cfg_pkg::PeakTrackIdx];
      exp_cnt++;
    end
    if (found || blocked) begin
      block_cnt = (block_cnt + 1) % tuner_cfg_pkg::PeakInvalidMax;
    end else begin
      block_cnt = 0;
    end
    rise_now   = win_hist[0].pwr > win_hist[1].pwr;
    fall_now   = win_hist[0].pwr < win_hist[1].pwr;
    rise_flags = {rise_flags[Size-2:0], rise_now};
    fall_flags = {fall_flags[Size-2:0], fall_now};
    for (int j = Size - 1; j > 0; j--) begin
      win_hist[j] = win_hist[j-1];
    end
    win_hist[0] = win_last;
    win_last    = s;
    n_samples++;
  endtask

  // Offered code is start plus k steps, ring owned meanwhile
  task automatic check_tune();
    tuner_cfg_pkg::tune_code_t exp_code;
    n_tunes++;
    exp_code = i_cfg.start_code + tuner_cfg_pkg::tune_code_t'(n_tunes << i_cfg.stride);
    check_value("o_ring_tune", i_ring_tune, exp_code);
    check_value("o_ctrl_active", i_ctrl_active, 1);
  endtask

  task automatic compare_results();
    check_value("tune fires", n_tunes, i_exp_samples);
    check_value("o_peaks_cnt", i_peaks_cnt, exp_cnt);
    for (int i = 0; i < tuner_cfg_pkg::NumTarget; i++) begin
      check_value($sformatf("o_peaks[%0d]", i), i_peaks[i], exp_tbl[i]);
    end
    // Ring released once results are offered
    check_value("o_ctrl_active", i_ctrl_active, 0);
    o_tests++;
    $display("test %0d: %0d samples, %0d peaks, %s", o_tests, n_tunes, exp_cnt,
             (test_errs == 0) ? "ok" : "mismatch");
  endtask

  // Reset values, seen as reset is released
  always @(negedge i_rst) begin
    check_value("o_trig_rdy", i_trig_rdy, 1);
    check_value("o_tune_val", i_tune_val, 0);
    check_value("o_commit_rdy", i_commit_rdy, 0);
    check_value("o_peaks_val", i_peaks_val, 0);
    check_value("o_ctrl_active", i_ctrl_active, 0);
    $display("reset test: %s", (test_errs == 0) ? "ok" : "mismatch");
  end

  // Pre-edge values of every handshake
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (i_trig_rdy && i_trig_val) begin
        clear_model();
      end
      if (i_tune_val && i_tune_rdy) begin
        check_tune();
      end
      if (i_commit_rdy && i_commit_val) begin
        apply_sample(i_commit);
      end
      // Stalled results must not move
      if (hold_prev) begin
        o_checks++;
        if (i_peaks !== prev_peaks || i_peaks_cnt !== prev_cnt) begin
          o_errors++;
          test_errs++;
          $display("** Error at %0t ns: o_peaks = 0x%h cnt %0d, expected 0x%h cnt %0d",
                   $time, i_peaks, i_peaks_cnt, prev_peaks, prev_cnt);
        end
      end
      if (i_peaks_val && i_peaks_rdy) begin
        compare_results();
      end
      hold_prev  = i_peaks_val && !i_peaks_rdy;
      prev_peaks = i_peaks;
      prev_cnt   = i_peaks_cnt;
    end
  end

endmodule

/* tb_tuner_search.sv */
// -----------------------------
// Tuner search testbench
// Clock, reset, sweep table and
// a ring arbiter model
// -----------------------------
`timescale 1ns/10ps

module tb_tuner_search;

  // One sweep per row, delays are upper bounds
  typedef struct packed {
    tuner_search_pkg::sweep_cfg_t cfg;
    logic [1:0]                   profile;
    logic [3:0]                   tune_dly;
    logic [3:0]                   commit_dly;
    logic [3:0]                   result_dly;
    tuner_cfg_pkg::sample_cnt_t   exp_samples;
  } row_t;

  localparam int NumRows = 8;

  logic                         clk;
  logic                         rst;
  tuner_search_pkg::sweep_cfg_t cfg;
  logic                         trig_val;
  logic                         trig_rdy;
  logic                         tune_val;
  tuner_cfg_pkg::tune_code_t    ring_tune;
  logic                         tune_rdy;
  logic                         commit_rdy;
  logic                         commit_val;
  tuner_search_pkg::sample_t    commit;
  logic                         ctrl_active;
  logic                         peaks_val;
  tuner_search_pkg::peak_tbl_t  peaks;
  tuner_cfg_pkg::peak_cnt_t     peaks_cnt;
  logic                         peaks_rdy;
  tuner_cfg_pkg::sample_cnt_t   exp_samples;
  int                           tests;
  int                           checks;
  int                           errors;
  row_t                         rows [NumRows];
  integer                       seed;
  int                           limit;
  int                           cycles;

  tuner_search_top i_dut (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_cfg         (cfg),
    .i_trig_val    (trig_val),
    .o_trig_rdy    (trig_rdy),
    .o_tune_val    (tune_val),
    .o_ring_tune   (ring_tune),
    .i_tune_rdy    (tune_rdy),
    .o_commit_rdy  (commit_rdy),
    .i_commit_val  (commit_val),
    .i_commit      (commit),
    .o_ctrl_active (ctrl_active),
    .o_peaks_val   (peaks_val),
    .o_peaks       (peaks),
    .o_peaks_cnt   (peaks_cnt),
    .i_peaks_rdy   (peaks_rdy)
  );

  tb_search_checker u_checker (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_cfg         (cfg),
    .i_exp_samples (exp_samples),
    .i_trig_val    (trig_val),
    .i_trig_rdy    (trig_rdy),
    .i_tune_val    (tune_val),
    .i_tune_rdy    (tune_rdy),
    .i_ring_tune   (ring_tune),
    .i_commit_rdy  (commit_rdy),
    .i_commit_val  (commit_val),
    .i_commit      (commit),
    .i_ctrl_active (ctrl_active),
    .i_peaks_val   (peaks_val),
    .i_peaks_rdy   (peaks_rdy),
    .i_peaks       (peaks),
    .i_peaks_cnt   (peaks_cnt),
    .o_tests       (tests),
    .o_checks      (checks),
    .o_errors      (errors)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic row_t make_row(input int start_code, input int end_code,
                                    input int stride, input int profile,
                                    input int td, input int cd, input int rd,
                                    input int n_exp);
    row_t r;
    r.cfg.start_code = tuner_cfg_pkg::tune_code_t'(start_code);
    r.cfg.end_code   = tuner_cfg_pkg::tune_code_t'(end_code);
    r.cfg.stride     = tuner_cfg_pkg::stride_t'(stride);
    r.profile        = 2'(profile);
    r.tune_dly       = 4'(td);
    r.commit_dly     = 4'(cd);
    r.result_dly     = 4'(rd);
    r.exp_samples    = tuner_cfg_pkg::sample_cnt_t'(n_exp);
    return r;
  endfunction

  // Triangle of given height and slope, floored at zero
  function automatic int triangle(input int c, input int center, input int top,
                                  input int slope);
    int d;
    int v;
    d = (c > center) ? (c - center) : (center - c);
    v = top - slope * d;
    return (v < 0) ? 0 : v;
  endfunction

  // Ring power seen at a code: flat, one peak, two close peaks, ramp
  function automatic tuner_cfg_pkg::pwr_t power_of(input logic [1:0] profile,
                                                   input tuner_cfg_pkg::tune_code_t code);
    int a;
    int b;
    int v;
    case (profile)
      2'd0: v = 40;
      2'd1: v = triangle(int'(code), 128, 200, 1);
      2'd2: begin
        a = triangle(int'(code), 100, 200, 4);
        b = triangle(int'(code), 112, 190, 4);
        v = (a > b) ? a : b;
      end
      default: v = int'(code);
    endcase
    return tuner_cfg_pkg::pwr_t'(v);
  endfunction

  function automatic int rand_delay(input int max_dly);
    if (max_dly == 0) begin
      return 0;
    end
    return int'($unsigned($random(seed)) % (max_dly + 1));
  endfunction

  // ------------------------------
  // One sweep with arbiter model
  // ------------------------------
  task automatic run_row(input row_t r);
    logic                      done;
    tuner_cfg_pkg::tune_code_t code;
    @(negedge clk);
    cfg         = r.cfg;
    exp_samples = r.exp_samples;
    trig_val    = 1'b1;
    @(negedge clk);
    trig_val = 1'b0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (peaks_val) begin
        done = 1'b1;
      end else if (tune_val) begin
        // Grant the tune request late, then commit the granted code
        repeat (rand_delay(r.tune_dly)) @(negedge clk);
        code     = ring_tune;
        tune_rdy = 1'b1;
        @(negedge clk);
        tune_rdy = 1'b0;
        repeat (rand_delay(r.commit_dly)) @(negedge clk);
        commit.code = code;
        commit.pwr  = power_of(r.profile, code);
        commit_val  = 1'b1;
        @(negedge clk);
        commit_val = 1'b0;
      end
    end
    // Results held while the reader stalls
    repeat (rand_delay(r.result_dly)) @(negedge clk);
    peaks_rdy = 1'b1;
    @(negedge clk);
    peaks_rdy = 1'b0;
  endtask

  // Hang guard
  initial begin
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run still busy after %0d cycles", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    limit       = 0;
    seed        = 32'h7dd6;
    rst         = 1'b1;
    cfg         = '0;
    trig_val    = 1'b0;
    tune_rdy    = 1'b0;
    commit_val  = 1'b0;
    commit      = '0;
    peaks_rdy   = 1'b0;
    exp_samples = '0;
    // start, end, stride, profile, tune/commit/result delay, samples
    rows[0] = make_row(96, 160, 0, 0, 0, 0, 0, 64);
    rows[1] = make_row(96, 160, 0, 1, 0, 0, 0, 64);
    rows[2] = make_row(124, 188, 0, 1, 0, 0, 0, 64);
    rows[3] = make_row(80, 144, 0, 2, 0, 0, 0, 64);
    rows[4] = make_row(80, 144, 1, 2, 0, 0, 0, 32);
    rows[5] = make_row(0, 255, 2, 3, 0, 0, 0, 63);
    rows[6] = make_row(96, 160, 0, 1, 3, 4, 6, 64);
    rows[7] = make_row(80, 144, 0, 2, 5, 2, 3, 64);
    // Worst-case handshake cycles per sample plus margins
    for (int i = 0; i < NumRows; i++) begin
      limit += int'(rows[i].exp_samples) * (rows[i].tune_dly + rows[i].commit_dly + 6);
      limit += rows[i].result_dly + 20;
    end
    limit += 110;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NumRows; i++) begin
      run_row(rows[i]);
    end
    repeat (4) @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && tests == NumRows) begin
      $display("ALL CHECKS PASSED");
    end else begin
      if (tests != NumRows) begin
        $display("Only %0d of %0d sweeps delivered results", tests, NumRows);
      end
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
tuner_cfg_pkg.sv
tuner_search_pkg.sv
search_ctrl.sv
ring_sweep.sv
peak_window.sv
peak_store.sv
tuner_search_top.sv
tb_search_checker.sv
tb_tuner_search.sv
